// File: tb.f
+incdir+.
regfile_pkg.sv
reg_cell.sv
regfile_bus_ctrl.sv
phy_addr_bank.sv
pkt_ctrl_bank.sv
mdio_access_bank.sv
top_regfile.sv
tb_top_regfile.sv

// File: tb_top_regfile.sv
// --------------------------------------------------
// Directed testbench for the APB register file:
// reset values, field readback, pulses, status
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module tb_top_regfile import regfile_pkg::*; ();

    // Transfers in all tests, cycles per transfer, margin
    localparam int XFERS          = 100;
    localparam int XFER_CYCLES    = 4;
    localparam int TIMEOUT_CYCLES = XFERS * XFER_CYCLES * 10;

    logic                      clk;
    logic                      rst;
    logic [`RF_ADDR_W-1:0]     paddr;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    logic [`RF_DATA_W-1:0]     pwdata;
    logic                      pready;
    logic [`RF_DATA_W-1:0]     prdata;
    phy_cfg_t                  phy_cfg;
    pkt_cfg_t                  pkt_cfg;
    mdio_cfg_t                 mdio_cfg;
    logic [`RF_PKT_DATA_W-1:0] mdio_pkt_data;
    logic                      mdio_pkt_data_we;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr_state = 32'h7418c445;

    // Expected register contents
    phy_cfg_t                  exp_phy;
    pkt_cfg_t                  exp_pkt;
    mdio_cfg_t                 exp_mdio;
    logic                      exp_rf_rstn;
    logic [`RF_PKT_DATA_W-1:0] exp_pkt_data;

    reg_addr_e all_addrs [11] = '{ADDR_PHY, ADDR_MODE, ADDR_PKT_TEST, ADDR_IDLE,
                                  ADDR_MDIO_MEM, ADDR_MDIO_SEL, ADDR_MDIO_DATA,
                                  ADDR_GAP, ADDR_PHASE, ADDR_CLK_EN, ADDR_SWRST};

    top_regfile i_dut (
        .clk              (clk),
        .rst              (rst),
        .paddr            (paddr),
        .pwrite           (pwrite),
        .psel             (psel),
        .penable          (penable),
        .pwdata           (pwdata),
        .pready           (pready),
        .prdata           (prdata),
        .phy_cfg          (phy_cfg),
        .pkt_cfg          (pkt_cfg),
        .mdio_cfg         (mdio_cfg),
        .mdio_pkt_data    (mdio_pkt_data),
        .mdio_pkt_data_we (mdio_pkt_data_we)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Random data, taps 32 22 2 1
    // --------------------------------------------------
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // --------------------------------------------------
    // Expected model from the register map
    // --------------------------------------------------
    function automatic void reset_model();
        exp_phy = '{legal_phy_addr: `RF_PHY_ADDR_RST, legal_phy_addr_mask: `RF_PHY_ADDR_RST,
                    broadcast_addr: `RF_PHY_ADDR_RST, broadcast_mode: `RF_BCAST_MODE_RST,
                    opendrain_mode: `RF_OPENDRAIN_RST, default: '0};
        exp_pkt = '{path96_en: `RF_PATH96_RST, pkt_idle_length: `RF_IDLE_LEN_RST,
                    pktctrl_clk_en: `RF_CLK_EN_RST, pktctrl_sw_rstn: `RF_SW_RSTN_RST,
                    default: '0};
        exp_mdio = '0;
        exp_rf_rstn = `RF_SW_RSTN_RST;
        exp_pkt_data = '0;
    endfunction

    function automatic void apply_write(input reg_addr_e a, input logic [15:0] d);
        case (a)
            ADDR_PHY: {exp_phy.legal_phy_addr, exp_phy.legal_phy_addr_mask,
                       exp_phy.broadcast_addr} = d[14:0];
            ADDR_MODE: {exp_phy.broadcast_mode, exp_phy.non_zero_detect, exp_phy.opendrain_mode,
                        exp_phy.watchdog_enable, exp_phy.sync_select} = d[4:0];
            ADDR_PKT_TEST: {exp_pkt.self_test_mode, exp_pkt.pkt_data_length,
                            exp_pkt.capture_mode, exp_pkt.capture_start,
                            exp_pkt.capture_again, exp_pkt.path96_en} = d[6:0];
            ADDR_IDLE:     exp_pkt.pkt_idle_length = d;
            ADDR_MDIO_MEM: exp_mdio.mdio_memory_addr = d[14:0];
            ADDR_MDIO_SEL: exp_mdio.mdio_data_sel = d[6:0];
            ADDR_GAP:      exp_pkt.pktctrl_gap = d[8:0];
            ADDR_PHASE:    exp_pkt.pktctrl_phase = d[8:0];
            ADDR_CLK_EN:   exp_pkt.pktctrl_clk_en = d[0];
            ADDR_SWRST:    {exp_pkt.pktctrl_sw_rstn, exp_rf_rstn} = d[1:0];
            default: ;
        endcase
    endfunction

    function automatic logic [15:0] word_of(input reg_addr_e a);
        case (a)
            ADDR_PHY: return {1'b0, exp_phy.legal_phy_addr, exp_phy.legal_phy_addr_mask,
                              exp_phy.broadcast_addr};
            ADDR_MODE: return {11'b0, exp_phy.broadcast_mode, exp_phy.non_zero_detect,
                               exp_phy.opendrain_mode, exp_phy.watchdog_enable,
                               exp_phy.sync_select};
            ADDR_PKT_TEST: return {9'b0, exp_pkt.self_test_mode, exp_pkt.pkt_data_length,
                                   exp_pkt.capture_mode, 2'b00, exp_pkt.path96_en};
            ADDR_IDLE:      return exp_pkt.pkt_idle_length;
            ADDR_MDIO_MEM:  return {1'b0, exp_mdio.mdio_memory_addr};
            ADDR_MDIO_SEL:  return {9'b0, exp_mdio.mdio_data_sel};
            ADDR_MDIO_DATA: return {7'b0, exp_pkt_data};
            ADDR_GAP:       return {7'b0, exp_pkt.pktctrl_gap};
            ADDR_PHASE:     return {7'b0, exp_pkt.pktctrl_phase};
            ADDR_CLK_EN:    return {15'b0, exp_pkt.pktctrl_clk_en};
            ADDR_SWRST:     return {14'b0, exp_pkt.pktctrl_sw_rstn, exp_rf_rstn};
            default:        return '0;
        endcase
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got 0x%04h expected 0x%04h", $time, what, got, exp);
        end
    endtask

    task automatic check_phy(input phy_cfg_t got, input phy_cfg_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: phy_cfg got 0x%h expected 0x%h", $time, got, exp);
        end
    endtask

    task automatic check_pkt(input pkt_cfg_t got, input pkt_cfg_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: pkt_cfg got 0x%h expected 0x%h", $time, got, exp);
        end
    endtask

    task automatic check_mdio(input mdio_cfg_t got, input mdio_cfg_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: mdio_cfg got 0x%h expected 0x%h", $time, got, exp);
        end
    endtask

    // --------------------------------------------------
    // APB transfers
    // --------------------------------------------------
    task automatic apb_transfer(input logic [`RF_ADDR_W-1:0] addr, input logic wr,
                                input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            errors++;
            $display("Access to address 0x%0h saw no pready in its access phase", addr);
        end
        rdata = prdata;
        // No read in progress during a write access
        if (wr) begin
            check_word(prdata, 16'h0000, $sformatf("prdata in write to 0x%0h", addr));
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [`RF_ADDR_W-1:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        apb_transfer(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(input logic [`RF_ADDR_W-1:0] addr, output logic [15:0] data);
        apb_transfer(addr, 1'b0, '0, data);
    endtask

    task automatic check_all();
        logic [15:0] rd;
        check_phy(phy_cfg, exp_phy);
        check_pkt(pkt_cfg, exp_pkt);
        check_mdio(mdio_cfg, exp_mdio);
        foreach (all_addrs[i]) begin
            apb_read(all_addrs[i], rd);
            check_word(rd, word_of(all_addrs[i]), $sformatf("read 0x%0h", all_addrs[i]));
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_values();
        if (pready !== 1'b0) begin
            errors++;
            $display("pready is high while the bus is idle after reset");
        end
        check_word(prdata, 16'h0000, "prdata while idle");
        check_all();
    endtask

    task automatic test_rw_fields();
        logic [15:0] d;
        logic [15:0] rd;
        for (int round = 0; round < 2; round++) begin
            foreach (all_addrs[i]) begin
                if (all_addrs[i] == ADDR_MDIO_DATA) begin
                    continue;
                end
                d = rand_bits(16);
                apb_write(all_addrs[i], d);
                apply_write(all_addrs[i], d);
                check_phy(phy_cfg, exp_phy);
                check_pkt(pkt_cfg, exp_pkt);
                check_mdio(mdio_cfg, exp_mdio);
                // Pulses are gone before the readback
                exp_pkt.capture_start = 1'b0;
                exp_pkt.capture_again = 1'b0;
                apb_read(all_addrs[i], rd);
                check_word(rd, word_of(all_addrs[i]), $sformatf("readback 0x%0h", all_addrs[i]));
            end
        end
    endtask

    task automatic test_self_clear();
        logic [15:0] rd;
        apb_write(ADDR_PKT_TEST, 16'h0057);
        apply_write(ADDR_PKT_TEST, 16'h0057);
        check_pkt(pkt_cfg, exp_pkt);
        exp_pkt.capture_start = 1'b0;
        exp_pkt.capture_again = 1'b0;
        @(posedge clk);
        #1;
        check_pkt(pkt_cfg, exp_pkt);
        apb_read(ADDR_PKT_TEST, rd);
        check_word(rd, word_of(ADDR_PKT_TEST), "packet test readback after pulse");
    endtask

    task automatic test_device_status();
        logic [15:0] v;
        logic [15:0] rd;
        v = rand_bits(9);
        @(posedge clk);
        #1;
        mdio_pkt_data = v[8:0];
        mdio_pkt_data_we = 1'b1;
        @(posedge clk);
        #1;
        mdio_pkt_data_we = 1'b0;
        exp_pkt_data = v[8:0];
        apb_read(ADDR_MDIO_DATA, rd);
        check_word(rd, word_of(ADDR_MDIO_DATA), "status after device write");
        apb_write(ADDR_MDIO_DATA, ~v);
        apb_read(ADDR_MDIO_DATA, rd);
        check_word(rd, word_of(ADDR_MDIO_DATA), "status after bus write");
    endtask

    task automatic test_unmapped();
        logic [`RF_ADDR_W-1:0] bad [3];
        logic [15:0]           rd;
        bad = '{21'h7, 21'hc, 21'h10001};
        foreach (bad[i]) begin
            apb_write(bad[i], rand_bits(16));
            apb_read(bad[i], rd);
            check_word(rd, 16'h0000, $sformatf("unmapped read 0x%0h", bad[i]));
        end
        check_all();
    endtask

    initial begin
        rst = 1'b1;
        paddr = '0;
        pwrite = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwdata = '0;
        mdio_pkt_data = '0;
        mdio_pkt_data_we = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_model();
        test_reset_values();
        test_rw_fields();
        test_self_clear();
        test_device_status();
        test_unmapped();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: top_regfile.sv
// -----------------------------------------------
// APB register file top: bus front end plus the
// PHY, packet-control and MDIO register banks
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module top_regfile import regfile_pkg::*; (
    input  wire                      clk,
    input  wire                      rst,

    input  wire [`RF_ADDR_W-1:0]     paddr,
    input  wire                      pwrite,
    input  wire                      psel,
    input  wire                      penable,
    input  wire [`RF_DATA_W-1:0]     pwdata,
    output wire                      pready,
    output wire [`RF_DATA_W-1:0]     prdata,

    output wire phy_cfg_t            phy_cfg,
    output wire pkt_cfg_t            pkt_cfg,
    output wire mdio_cfg_t           mdio_cfg,

    input  wire [`RF_PKT_DATA_W-1:0] mdio_pkt_data,
    input  wire                      mdio_pkt_data_we
);

    wire apb_req_t  req;
    wire reg_wr_t   wr;
    wire rd_words_t rd_words;

    assign req = '{paddr: paddr, pwrite: pwrite, psel: psel,
                   penable: penable, pwdata: pwdata};

    regfile_bus_ctrl u_bus_ctrl (
        .req      (req),
        .wr       (wr),
        .rd_words (rd_words),
        .pready   (pready),
        .prdata   (prdata)
    );

    phy_addr_bank u_phy_addr_bank (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .cfg   (phy_cfg),
        .words (rd_words.phy)
    );

    pkt_ctrl_bank u_pkt_ctrl_bank (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .cfg   (pkt_cfg),
        .words (rd_words.pkt)
    );

    mdio_access_bank u_mdio_access_bank (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .pkt_data    (mdio_pkt_data),
        .pkt_data_we (mdio_pkt_data_we),
        .cfg         (mdio_cfg),
        .words       (rd_words.mdio)
    );

endmodule

`default_nettype wire

// File: mdio_access_bank.sv
// -----------------------------------------------
// MDIO access registers (0x4, 0x5) and the
// device-written packet data status (0x6)
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module mdio_access_bank import regfile_pkg::*; (
    input  wire                      clk,
    input  wire                      rst,
    input  wire reg_wr_t             wr,
    input  wire [`RF_PKT_DATA_W-1:0] pkt_data,
    input  wire                      pkt_data_we,
    output mdio_cfg_t                cfg,
    output mdio_words_t              words
);

    logic [`RF_PKT_DATA_W-1:0] pkt_data_q;

    reg_cell #(.W(`RF_MDIO_MEM_W), .INIT('0)) u_mdio_memory_addr (
        .clk   (clk),
        .rst   (rst),
        .we    (wr.strb[ADDR_MDIO_MEM]),
        .wdata (wr.data[`RF_MDIO_MEM_W-1:0]),
        .q     (cfg.mdio_memory_addr)
    );

    reg_cell #(.W(`RF_MDIO_SEL_W), .INIT('0)) u_mdio_data_sel (
        .clk   (clk),
        .rst   (rst),
        .we    (wr.strb[ADDR_MDIO_SEL]),
        .wdata (wr.data[`RF_MDIO_SEL_W-1:0]),
        .q     (cfg.mdio_data_sel)
    );

    // -----------------------------------------------
    // Status captured from the device side
    // -----------------------------------------------
    // Bus writes to 0x6 have no path here
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_data_q <= '0;
        end else if (pkt_data_we) begin
            pkt_data_q <= pkt_data;
        end
    end

    assign words.mem_addr = {1'b0, cfg.mdio_memory_addr};
    assign words.data_sel = {9'b0, cfg.mdio_data_sel};
    assign words.pkt_data = {7'b0, pkt_data_q};

endmodule

`default_nettype wire

// File: pkt_ctrl_bank.sv
// -----------------------------------------------
// Packet test and packet-control registers
// (0x2, 0x3, 0x8 to 0xb)
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module pkt_ctrl_bank import regfile_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire reg_wr_t wr,
    output pkt_cfg_t     cfg,
    output pkt_words_t   words
);

    logic regfile_sw_rstn;

    // -----------------------------------------------
    // Packet test control, 0x2
    // -----------------------------------------------
    reg_cell #(.W(1), .INIT(1'b0)) u_self_test_mode (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[6]),
        .q(cfg.self_test_mode)
    );
    reg_cell #(.W(`RF_PKT_LEN_W), .INIT('0)) u_pkt_data_length (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[5:4]),
        .q(cfg.pkt_data_length)
    );
    reg_cell #(.W(1), .INIT(1'b0)) u_capture_mode (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[3]),
        .q(cfg.capture_mode)
    );
    // Start and again are one-cycle pulses
    reg_cell #(.W(1), .INIT(1'b0), .SELF_CLEAR(1'b1)) u_capture_start (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[2]),
        .q(cfg.capture_start)
    );
    reg_cell #(.W(1), .INIT(1'b0), .SELF_CLEAR(1'b1)) u_capture_again (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[1]),
        .q(cfg.capture_again)
    );
    reg_cell #(.W(1), .INIT(`RF_PATH96_RST)) u_path96_en (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PKT_TEST]), .wdata(wr.data[0]),
        .q(cfg.path96_en)
    );

    reg_cell #(.W(`RF_IDLE_LEN_W), .INIT(`RF_IDLE_LEN_RST)) u_pkt_idle_length (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_IDLE]), .wdata(wr.data),
        .q(cfg.pkt_idle_length)
    );

    // -----------------------------------------------
    // Packet control, 0x8 to 0xb
    // -----------------------------------------------
    reg_cell #(.W(`RF_GAP_W), .INIT('0)) u_pktctrl_gap (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_GAP]), .wdata(wr.data[`RF_GAP_W-1:0]),
        .q(cfg.pktctrl_gap)
    );
    reg_cell #(.W(`RF_PHASE_W), .INIT('0)) u_pktctrl_phase (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PHASE]), .wdata(wr.data[`RF_PHASE_W-1:0]),
        .q(cfg.pktctrl_phase)
    );
    reg_cell #(.W(1), .INIT(`RF_CLK_EN_RST)) u_pktctrl_clk_en (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_CLK_EN]), .wdata(wr.data[0]),
        .q(cfg.pktctrl_clk_en)
    );
    reg_cell #(.W(1), .INIT(`RF_SW_RSTN_RST)) u_pktctrl_sw_rstn (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_SWRST]), .wdata(wr.data[1]),
        .q(cfg.pktctrl_sw_rstn)
    );
    // Readback only, drives no reset
    reg_cell #(.W(1), .INIT(`RF_SW_RSTN_RST)) u_regfile_sw_rstn (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_SWRST]), .wdata(wr.data[0]),
        .q(regfile_sw_rstn)
    );

    // Pulse bits always read as zero
    assign words.pkt_test = {9'b0, cfg.self_test_mode, cfg.pkt_data_length,
                             cfg.capture_mode, 1'b0, 1'b0, cfg.path96_en};
    assign words.idle     = cfg.pkt_idle_length;
    assign words.gap      = {7'b0, cfg.pktctrl_gap};
    assign words.phase    = {7'b0, cfg.pktctrl_phase};
    assign words.clk_en   = {15'b0, cfg.pktctrl_clk_en};
    assign words.swrst    = {14'b0, cfg.pktctrl_sw_rstn, regfile_sw_rstn};

endmodule

`default_nettype wire

// File: phy_addr_bank.sv
// -----------------------------------------------
// PHY addressing and mode registers (0x0, 0x1)
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module phy_addr_bank import regfile_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire reg_wr_t wr,
    output phy_cfg_t     cfg,
    output phy_words_t   words
);

    // Address 0x0
    reg_cell #(.W(`RF_PHY_ADDR_W), .INIT(`RF_PHY_ADDR_RST)) u_legal_phy_addr (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PHY]), .wdata(wr.data[14:10]),
        .q(cfg.legal_phy_addr)
    );
    reg_cell #(.W(`RF_PHY_ADDR_W), .INIT(`RF_PHY_ADDR_RST)) u_legal_phy_addr_mask (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PHY]), .wdata(wr.data[9:5]),
        .q(cfg.legal_phy_addr_mask)
    );
    reg_cell #(.W(`RF_PHY_ADDR_W), .INIT(`RF_PHY_ADDR_RST)) u_broadcast_addr (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_PHY]), .wdata(wr.data[4:0]),
        .q(cfg.broadcast_addr)
    );

    // Address 0x1 mode bits
    reg_cell #(.W(1), .INIT(`RF_BCAST_MODE_RST)) u_broadcast_mode (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_MODE]), .wdata(wr.data[4]),
        .q(cfg.broadcast_mode)
    );
    reg_cell #(.W(1), .INIT(1'b0)) u_non_zero_detect (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_MODE]), .wdata(wr.data[3]),
        .q(cfg.non_zero_detect)
    );
    reg_cell #(.W(1), .INIT(`RF_OPENDRAIN_RST)) u_opendrain_mode (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_MODE]), .wdata(wr.data[2]),
        .q(cfg.opendrain_mode)
    );
    reg_cell #(.W(1), .INIT(1'b0)) u_watchdog_enable (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_MODE]), .wdata(wr.data[1]),
        .q(cfg.watchdog_enable)
    );
    reg_cell #(.W(1), .INIT(1'b0)) u_sync_select (
        .clk(clk), .rst(rst), .we(wr.strb[ADDR_MODE]), .wdata(wr.data[0]),
        .q(cfg.sync_select)
    );

    assign words.phy_addr = {1'b0, cfg.legal_phy_addr, cfg.legal_phy_addr_mask,
                             cfg.broadcast_addr};
    assign words.mode     = {11'b0, cfg.broadcast_mode, cfg.non_zero_detect,
                             cfg.opendrain_mode, cfg.watchdog_enable, cfg.sync_select};

endmodule

`default_nettype wire

// File: regfile_bus_ctrl.sv
// -----------------------------------------------
// APB slave front end: address decode, write
// strobes, pready and readback multiplexer
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "regfile_consts.svh"

module regfile_bus_ctrl import regfile_pkg::*; (
    input  wire apb_req_t             req,
    output reg_wr_t                   wr,
    input  wire rd_words_t            rd_words,
    output logic                      pready,
    output logic [`RF_DATA_W-1:0]     prdata
);

    logic      access;
    reg_addr_e addr;

    // Access phase, zero wait states
    assign access = req.psel & req.penable;
    assign pready = access;

    // Only the low index bits may be set for a mapped register
    always_comb begin
        addr = ADDR_NONE;
        if (req.paddr[`RF_ADDR_W-1:`RF_IDX_W] == '0) begin
            case (req.paddr[`RF_IDX_W-1:0])
                ADDR_PHY, ADDR_MODE, ADDR_PKT_TEST, ADDR_IDLE,
                ADDR_MDIO_MEM, ADDR_MDIO_SEL, ADDR_MDIO_DATA,
                ADDR_GAP, ADDR_PHASE, ADDR_CLK_EN, ADDR_SWRST: begin
                    addr = reg_addr_e'(req.paddr[`RF_IDX_W-1:0]);
                end
                default: begin
                    addr = ADDR_NONE;
                end
            endcase
        end
    end

    always_comb begin
        wr      = '0;
        wr.data = req.pwdata;
        if (access && req.pwrite && addr != ADDR_NONE) begin
            wr.strb[addr] = 1'b1;
        end
    end

    // -----------------------------------------------
    // Readback
    // -----------------------------------------------
    always_comb begin
        prdata = '0;
        if (access && !req.pwrite) begin
            case (addr)
                ADDR_PHY:       prdata = rd_words.phy.phy_addr;
                ADDR_MODE:      prdata = rd_words.phy.mode;
                ADDR_PKT_TEST:  prdata = rd_words.pkt.pkt_test;
                ADDR_IDLE:      prdata = rd_words.pkt.idle;
                ADDR_MDIO_MEM:  prdata = rd_words.mdio.mem_addr;
                ADDR_MDIO_SEL:  prdata = rd_words.mdio.data_sel;
                ADDR_MDIO_DATA: prdata = rd_words.mdio.pkt_data;
                ADDR_GAP:       prdata = rd_words.pkt.gap;
                ADDR_PHASE:     prdata = rd_words.pkt.phase;
                ADDR_CLK_EN:    prdata = rd_words.pkt.clk_en;
                ADDR_SWRST:     prdata = rd_words.pkt.swrst;
                default:        prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: reg_cell.sv
// -----------------------------------------------
// Single field register, loaded by a write strobe,
// with optional self-clear one cycle after load
// -----------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module reg_cell #(
    parameter int         W          = 1,
    parameter logic [W-1:0] INIT     = '0,
    parameter bit         SELF_CLEAR = 1'b0
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           we,
    input  wire [W-1:0]   wdata,
    output logic [W-1:0]  q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= INIT;
        end else if (we) begin
            q <= wdata;
        end else if (SELF_CLEAR) begin
            // Pulse field, back to zero after one cycle
            q <= '0;
        end
    end

endmodule

`default_nettype wire

// File: regfile_pkg.sv
// -----------------------------------------------
// Register file types: address enum, bus request,
// write strobes, readback words and config groups
// -----------------------------------------------
`default_nettype none

`include "regfile_consts.svh"

package regfile_pkg;

    typedef enum logic [`RF_IDX_W-1:0] {
        ADDR_PHY       = `RF_ADDR_PHY,
        ADDR_MODE      = `RF_ADDR_MODE,
        ADDR_PKT_TEST  = `RF_ADDR_PKT_TEST,
        ADDR_IDLE      = `RF_ADDR_IDLE,
        ADDR_MDIO_MEM  = `RF_ADDR_MDIO_MEM,
        ADDR_MDIO_SEL  = `RF_ADDR_MDIO_SEL,
        ADDR_MDIO_DATA = `RF_ADDR_MDIO_DATA,
        ADDR_GAP       = `RF_ADDR_GAP,
        ADDR_PHASE     = `RF_ADDR_PHASE,
        ADDR_CLK_EN    = `RF_ADDR_CLK_EN,
        ADDR_SWRST     = `RF_ADDR_SWRST,
        ADDR_NONE      = `RF_ADDR_NONE
    } reg_addr_e;

    typedef struct packed {
        logic [`RF_ADDR_W-1:0] paddr;
        logic                  pwrite;
        logic                  psel;
        logic                  penable;
        logic [`RF_DATA_W-1:0] pwdata;
    } apb_req_t;

    // One strobe per register index
    typedef struct packed {
        logic [(1 << `RF_IDX_W)-1:0] strb;
        logic [`RF_DATA_W-1:0]       data;
    } reg_wr_t;

    // -----------------------------------------------
    // Configuration groups
    // -----------------------------------------------
    typedef struct packed {
        logic [`RF_PHY_ADDR_W-1:0] legal_phy_addr;
        logic [`RF_PHY_ADDR_W-1:0] legal_phy_addr_mask;
        logic [`RF_PHY_ADDR_W-1:0] broadcast_addr;
        logic                      broadcast_mode;
        logic                      non_zero_detect;
        logic                      opendrain_mode;
        logic                      watchdog_enable;
        logic                      sync_select;
    } phy_cfg_t;

    typedef struct packed {
        logic                      self_test_mode;
        logic [`RF_PKT_LEN_W-1:0]  pkt_data_length;
        logic                      capture_mode;
        logic                      capture_start;
        logic                      capture_again;
        logic                      path96_en;
        logic [`RF_IDLE_LEN_W-1:0] pkt_idle_length;
        logic [`RF_GAP_W-1:0]      pktctrl_gap;
        logic [`RF_PHASE_W-1:0]    pktctrl_phase;
        logic                      pktctrl_clk_en;
        logic                      pktctrl_sw_rstn;
    } pkt_cfg_t;

    typedef struct packed {
        logic [`RF_MDIO_SEL_W-1:0] mdio_data_sel;
        logic [`RF_MDIO_MEM_W-1:0] mdio_memory_addr;
    } mdio_cfg_t;

    // -----------------------------------------------
    // Readback words, one part per bank
    // -----------------------------------------------
    typedef struct packed {
        logic [`RF_DATA_W-1:0] phy_addr;
        logic [`RF_DATA_W-1:0] mode;
    } phy_words_t;

    typedef struct packed {
        logic [`RF_DATA_W-1:0] pkt_test;
        logic [`RF_DATA_W-1:0] idle;
        logic [`RF_DATA_W-1:0] gap;
        logic [`RF_DATA_W-1:0] phase;
        logic [`RF_DATA_W-1:0] clk_en;
        logic [`RF_DATA_W-1:0] swrst;
    } pkt_words_t;

    typedef struct packed {
        logic [`RF_DATA_W-1:0] mem_addr;
        logic [`RF_DATA_W-1:0] data_sel;
        logic [`RF_DATA_W-1:0] pkt_data;
    } mdio_words_t;

    typedef struct packed {
        phy_words_t  phy;
        pkt_words_t  pkt;
        mdio_words_t mdio;
    } rd_words_t;

endpackage

`default_nettype wire

// File: regfile_consts.svh
// -----------------------------------------------
// Register file constants: bus widths, register
// addresses, field widths and field reset values
// -----------------------------------------------
`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

`define RF_ADDR_W          21
`define RF_DATA_W          16
`define RF_IDX_W           4

// Register map
`define RF_ADDR_PHY        4'h0
`define RF_ADDR_MODE       4'h1
`define RF_ADDR_PKT_TEST   4'h2
`define RF_ADDR_IDLE       4'h3
`define RF_ADDR_MDIO_MEM   4'h4
`define RF_ADDR_MDIO_SEL   4'h5
`define RF_ADDR_MDIO_DATA  4'h6
`define RF_ADDR_GAP        4'h8
`define RF_ADDR_PHASE      4'h9
`define RF_ADDR_CLK_EN     4'ha
`define RF_ADDR_SWRST      4'hb
`define RF_ADDR_NONE       4'hf

// Field widths
`define RF_PHY_ADDR_W      5
`define RF_PKT_LEN_W       2
`define RF_IDLE_LEN_W      16
`define RF_MDIO_MEM_W      15
`define RF_MDIO_SEL_W      7
`define RF_PKT_DATA_W      9
`define RF_GAP_W           9
`define RF_PHASE_W         9

// Non-zero reset values
`define RF_PHY_ADDR_RST    5'h1f
`define RF_BCAST_MODE_RST  1'b1
`define RF_OPENDRAIN_RST   1'b1
`define RF_PATH96_RST      1'b1
`define RF_IDLE_LEN_RST    16'h7fff
`define RF_CLK_EN_RST      1'b1
`define RF_SW_RSTN_RST     1'b1

`endif
